// ==== design/hdmi_pkg.sv ====
`default_nettype none

package hdmi_pkg;

    // Horizontal frame geometry in pixels
    localparam int h_active = 16;
    localparam int h_front  = 2;
    localparam int h_sync   = 4;
    localparam int h_back   = 4;
    localparam int h_total  = h_active + h_front + h_sync + h_back;

    // Vertical frame geometry in lines
    localparam int v_active = 4;
    localparam int v_front  = 1;
    localparam int v_sync   = 2;
    localparam int v_back   = 2;
    localparam int v_total  = v_active + v_front + v_sync + v_back;

    localparam int h_cnt_w = $clog2(h_total);
    localparam int v_cnt_w = $clog2(v_total);

    // Fast clocks per pixel
    localparam int strobe_div = 5;

    // Control symbols, indexed by {c1, c0}
    localparam logic [9:0] tmds_ctrl0 = 10'b1101010100;
    localparam logic [9:0] tmds_ctrl1 = 10'b0010101011;
    localparam logic [9:0] tmds_ctrl2 = 10'b0101010100;
    localparam logic [9:0] tmds_ctrl3 = 10'b1010101011;

    // LSB goes out first, so five zeros then five ones on the wire
    localparam logic [9:0] clock_lane_word = 10'b11111_00000;

    // APB byte addresses
    localparam logic [3:0] addr_ctrl   = 4'h0;
    localparam logic [3:0] addr_color  = 4'h4;
    localparam logic [3:0] addr_status = 4'h8;

    typedef enum logic [1:0] {
        pat_solid = 2'd0,
        pat_bars  = 2'd1,
        pat_ramp  = 2'd2
    } pattern_t;

endpackage

`default_nettype wire

// ==== design/video_timing.sv ====
`timescale 1ns/100ps
`default_nettype none

module video_timing
(
    input  logic                          clk_pixel_x5,
    input  logic                          arst_n,
    output logic                          pix_strobe,
    output logic [hdmi_pkg::h_cnt_w-1:0]  h_cnt,
    output logic [hdmi_pkg::v_cnt_w-1:0]  v_cnt,
    output logic                          hsync,
    output logic                          vsync,
    output logic                          de,
    output logic [15:0]                   frame_count
);

    logic [$clog2(hdmi_pkg::strobe_div)-1:0] div_cnt;
    logic [hdmi_pkg::h_cnt_w-1:0]            h_next;
    logic [hdmi_pkg::v_cnt_w-1:0]            v_next;

    // Divide by five, strobe is high in the last cycle of each pixel
    always_ff @(posedge clk_pixel_x5 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            div_cnt    <= '0;
            pix_strobe <= 1'b0;
        end
        else
        begin
            if (div_cnt == $bits(div_cnt)'(hdmi_pkg::strobe_div - 1))
                div_cnt <= '0;
            else
                div_cnt <= div_cnt + 1'b1;
            pix_strobe <= (div_cnt == $bits(div_cnt)'(hdmi_pkg::strobe_div - 2));
        end
    end

    always_comb
    begin
        h_next = h_cnt + 1'b1;
        v_next = v_cnt;
        if (h_cnt == hdmi_pkg::h_cnt_w'(hdmi_pkg::h_total - 1))
        begin
            h_next = '0;
            if (v_cnt == hdmi_pkg::v_cnt_w'(hdmi_pkg::v_total - 1))
                v_next = '0;
            else
                v_next = v_cnt + 1'b1;
        end
    end

    // Flags are computed from the next position so they move with the counters
    always_ff @(posedge clk_pixel_x5 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            h_cnt       <= '0;
            v_cnt       <= '0;
            hsync       <= 1'b0;
            vsync       <= 1'b0;
            // (0,0) is an active pixel
            de          <= 1'b1;
            frame_count <= '0;
        end
        else if (pix_strobe)
        begin
            h_cnt <= h_next;
            v_cnt <= v_next;
            hsync <= (h_next >= hdmi_pkg::h_cnt_w'(hdmi_pkg::h_active + hdmi_pkg::h_front)) &&
                     (h_next < hdmi_pkg::h_cnt_w'(hdmi_pkg::h_active + hdmi_pkg::h_front +
                                                  hdmi_pkg::h_sync));
            vsync <= (v_next >= hdmi_pkg::v_cnt_w'(hdmi_pkg::v_active + hdmi_pkg::v_front)) &&
                     (v_next < hdmi_pkg::v_cnt_w'(hdmi_pkg::v_active + hdmi_pkg::v_front +
                                                  hdmi_pkg::v_sync));
            de    <= (h_next < hdmi_pkg::h_cnt_w'(hdmi_pkg::h_active)) &&
                     (v_next < hdmi_pkg::v_cnt_w'(hdmi_pkg::v_active));
            if (h_next == '0 && v_next == '0)
                frame_count <= frame_count + 1'b1;
        end
    end

    a_strobe_single: assert property (@(posedge clk_pixel_x5) disable iff (!arst_n)
        pix_strobe |=> !pix_strobe);

endmodule

`default_nettype wire

// ==== design/pattern_source.sv ====
`timescale 1ns/100ps
`default_nettype none

module pattern_source
(
    input  logic                          clk_pixel_x5,
    input  logic                          arst_n,
    input  logic                          pix_strobe,
    input  logic [hdmi_pkg::h_cnt_w-1:0]  h_cnt,
    input  logic [hdmi_pkg::v_cnt_w-1:0]  v_cnt,
    input  logic                          de_in,
    input  logic                          hsync_in,
    input  logic                          vsync_in,
    input  logic                          enable,
    input  hdmi_pkg::pattern_t            pattern,
    input  logic [23:0]                   solid_color,
    output logic [7:0]                    red,
    output logic [7:0]                    green,
    output logic [7:0]                    blue,
    output logic                          de,
    output logic                          hsync,
    output logic                          vsync
);

    logic        active;
    logic [7:0]  ramp;
    logic [23:0] pix;

    assign active = (h_cnt < hdmi_pkg::h_cnt_w'(hdmi_pkg::h_active)) &&
                    (v_cnt < hdmi_pkg::v_cnt_w'(hdmi_pkg::v_active));

    // h_cnt times 16
    assign ramp = {h_cnt[3:0], 4'h0};

    always_comb
    begin
        pix = '0;
        if (enable && active)
        begin
            case (pattern)
                hdmi_pkg::pat_solid: pix = solid_color;
                // Bar index is h_cnt / 2, one bit per component
                hdmi_pkg::pat_bars:  pix = {{8{h_cnt[3]}}, {8{h_cnt[2]}}, {8{h_cnt[1]}}};
                hdmi_pkg::pat_ramp:  pix = {ramp, ramp, ramp};
                default:             pix = '0;
            endcase
        end
    end

    always_ff @(posedge clk_pixel_x5)
    begin
        if (pix_strobe)
            {red, green, blue} <= pix;
    end

    always_ff @(posedge clk_pixel_x5 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            de    <= 1'b0;
            hsync <= 1'b0;
            vsync <= 1'b0;
        end
        else if (pix_strobe)
        begin
            de    <= de_in;
            hsync <= hsync_in;
            vsync <= vsync_in;
        end
    end

endmodule

`default_nettype wire

// ==== design/tmds_encoder.sv ====
`timescale 1ns/100ps
`default_nettype none

module tmds_encoder
(
    input  logic       clk_pixel_x5,
    input  logic       arst_n,
    input  logic       pix_strobe,
    input  logic [7:0] data,
    input  logic       c0,
    input  logic       c1,
    input  logic       de,
    output logic [9:0] symbol
);

    logic [3:0]        n1_d;
    logic [3:0]        n1_q;
    logic              use_xnor;
    logic [8:0]        q_m;
    logic [9:0]        q_out;
    logic [9:0]        ctrl_sym;
    // Ones minus zeros of q_m[7:0]
    logic signed [5:0] diff;
    logic signed [5:0] disp;
    logic signed [5:0] disp_next;

    // Stage 1, transition minimisation
    always_comb
    begin
        n1_d     = 4'($countones(data));
        use_xnor = (n1_d > 4'd4) || (n1_d == 4'd4 && !data[0]);
        q_m[0]   = data[0];
        for (int i = 1; i < 8; i++)
        begin
            q_m[i] = use_xnor ? ~(q_m[i-1] ^ data[i]) : (q_m[i-1] ^ data[i]);
        end
        q_m[8] = ~use_xnor;
        n1_q   = 4'($countones(q_m[7:0]));
        diff   = $signed({1'b0, n1_q, 1'b0}) - 6'sd8;
    end

    // Stage 2, DC balance against the running disparity
    always_comb
    begin
        if (disp == 6'sd0 || diff == 6'sd0)
        begin
            q_out     = {~q_m[8], q_m[8], q_m[8] ? q_m[7:0] : ~q_m[7:0]};
            disp_next = q_m[8] ? disp + diff : disp - diff;
        end
        else if ((disp > 6'sd0 && diff > 6'sd0) || (disp < 6'sd0 && diff < 6'sd0))
        begin
            q_out     = {1'b1, q_m[8], ~q_m[7:0]};
            disp_next = disp - diff + (q_m[8] ? 6'sd2 : 6'sd0);
        end
        else
        begin
            q_out     = {1'b0, q_m[8], q_m[7:0]};
            disp_next = disp + diff - (q_m[8] ? 6'sd0 : 6'sd2);
        end
    end

    always_comb
    begin
        case ({c1, c0})
            2'b00:   ctrl_sym = hdmi_pkg::tmds_ctrl0;
            2'b01:   ctrl_sym = hdmi_pkg::tmds_ctrl1;
            2'b10:   ctrl_sym = hdmi_pkg::tmds_ctrl2;
            default: ctrl_sym = hdmi_pkg::tmds_ctrl3;
        endcase
    end

    always_ff @(posedge clk_pixel_x5 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            symbol <= '0;
            disp   <= '0;
        end
        else if (pix_strobe)
        begin
            if (de)
            begin
                symbol <= q_out;
                disp   <= disp_next;
            end
            else
            begin
                // Blanking restarts the balance
                symbol <= ctrl_sym;
                disp   <= '0;
            end
        end
    end

    a_disp_bounded: assert property (@(posedge clk_pixel_x5) disable iff (!arst_n)
        pix_strobe |=> (disp <= 6'sd8) && (disp >= -6'sd8));

endmodule

`default_nettype wire

// ==== design/serializer.sv ====
`timescale 1ns/100ps
`default_nettype none

module serializer
(
    input  logic       clk_pixel_x5,
    input  logic       arst_n,
    input  logic       pix_strobe,
    input  logic [9:0] tmds_word_0,
    input  logic [9:0] tmds_word_1,
    input  logic [9:0] tmds_word_2,
    output logic [1:0] tmds_0,
    output logic [1:0] tmds_1,
    output logic [1:0] tmds_2,
    output logic [1:0] tmds_clock
);

    // Lane 3 is the clock lane
    logic [3:0][9:0] shreg;

    always_ff @(posedge clk_pixel_x5 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            shreg <= '0;
        end
        else if (pix_strobe)
        begin
            shreg <= {hdmi_pkg::clock_lane_word, tmds_word_2, tmds_word_1, tmds_word_0};
        end
        else
        begin
            for (int i = 0; i < 4; i++)
            begin
                shreg[i] <= {2'b00, shreg[i][9:2]};
            end
        end
    end

    // Pair bit 0 is the earlier bit of the two
    assign tmds_0     = shreg[0][1:0];
    assign tmds_1     = shreg[1][1:0];
    assign tmds_2     = shreg[2][1:0];
    assign tmds_clock = shreg[3][1:0];

    a_load_period: assert property (@(posedge clk_pixel_x5) disable iff (!arst_n)
        pix_strobe |=> !pix_strobe [*hdmi_pkg::strobe_div-1] ##1 pix_strobe);

endmodule

`default_nettype wire

// ==== design/apb_regs.sv ====
`timescale 1ns/100ps
`default_nettype none

module apb_regs
(
    input  logic               clk_pixel_x5,
    input  logic               arst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [3:0]         paddr,
    input  logic [31:0]        pwdata,
    output logic [31:0]        prdata,
    output logic               pready,
    output logic               pslverr,
    input  logic [15:0]        frame_count,
    output logic               enable,
    output hdmi_pkg::pattern_t pattern,
    output logic [23:0]        solid_color
);

    logic        setup;
    logic        access;
    logic        addr_err;
    logic [31:0] rdata;

    assign setup  = psel && !penable;
    assign access = psel && penable;
    assign pready = 1'b1;

    always_comb
    begin
        addr_err = 1'b0;
        rdata    = '0;
        case (paddr)
            hdmi_pkg::addr_ctrl:   rdata = {29'd0, pattern, enable};
            hdmi_pkg::addr_color:  rdata = {8'd0, solid_color};
            hdmi_pkg::addr_status:
            begin
                rdata    = {16'd0, frame_count};
                addr_err = pwrite;
            end
            default:               addr_err = 1'b1;
        endcase
    end

    // Response is captured in setup and held through the access cycle
    always_ff @(posedge clk_pixel_x5 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end
        else if (setup)
        begin
            prdata  <= (pwrite || addr_err) ? '0 : rdata;
            pslverr <= addr_err;
        end
        else
        begin
            prdata  <= '0;
            pslverr <= 1'b0;
        end
    end

    always_ff @(posedge clk_pixel_x5 or negedge arst_n)
    begin
        if (!arst_n)
        begin
            enable      <= 1'b0;
            pattern     <= hdmi_pkg::pat_solid;
            solid_color <= '0;
        end
        else if (access && pwrite && !addr_err)
        begin
            if (paddr == hdmi_pkg::addr_ctrl)
            begin
                enable  <= pwdata[0];
                pattern <= hdmi_pkg::pattern_t'(pwdata[2:1]);
            end
            if (paddr == hdmi_pkg::addr_color)
                solid_color <= pwdata[23:0];
        end
    end

    a_penable_psel: assert property (@(posedge clk_pixel_x5) disable iff (!arst_n)
        penable |-> psel);

endmodule

`default_nettype wire

// ==== design/hdmi_tx.sv ====
`timescale 1ns/100ps
`default_nettype none

module hdmi_tx
(
    input  logic        clk_pixel_x5,
    input  logic        arst_n,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [3:0]  paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic [1:0]  tmds_0,
    output logic [1:0]  tmds_1,
    output logic [1:0]  tmds_2,
    output logic [1:0]  tmds_clock
);

    logic                         pix_strobe;
    logic [hdmi_pkg::h_cnt_w-1:0] h_cnt;
    logic [hdmi_pkg::v_cnt_w-1:0] v_cnt;
    logic                         hsync_t;
    logic                         vsync_t;
    logic                         de_t;
    logic [15:0]                  frame_count;
    logic                         enable;
    hdmi_pkg::pattern_t           pattern;
    logic [23:0]                  solid_color;
    logic [7:0]                   red;
    logic [7:0]                   green;
    logic [7:0]                   blue;
    logic                         de_p;
    logic                         hsync_p;
    logic                         vsync_p;
    logic [9:0]                   tmds_word_0;
    logic [9:0]                   tmds_word_1;
    logic [9:0]                   tmds_word_2;

    video_timing timing0
    (
        .clk_pixel_x5 (clk_pixel_x5),
        .arst_n       (arst_n),
        .pix_strobe   (pix_strobe),
        .h_cnt        (h_cnt),
        .v_cnt        (v_cnt),
        .hsync        (hsync_t),
        .vsync        (vsync_t),
        .de           (de_t),
        .frame_count  (frame_count)
    );

    pattern_source pattern0
    (
        .clk_pixel_x5 (clk_pixel_x5),
        .arst_n       (arst_n),
        .pix_strobe   (pix_strobe),
        .h_cnt        (h_cnt),
        .v_cnt        (v_cnt),
        .de_in        (de_t),
        .hsync_in     (hsync_t),
        .vsync_in     (vsync_t),
        .enable       (enable),
        .pattern      (pattern),
        .solid_color  (solid_color),
        .red          (red),
        .green        (green),
        .blue         (blue),
        .de           (de_p),
        .hsync        (hsync_p),
        .vsync        (vsync_p)
    );

    apb_regs regs0
    (
        .clk_pixel_x5 (clk_pixel_x5),
        .arst_n       (arst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .frame_count  (frame_count),
        .enable       (enable),
        .pattern      (pattern),
        .solid_color  (solid_color)
    );

    // Sync rides on the blue channel only
    tmds_encoder enc0
    (
        .clk_pixel_x5 (clk_pixel_x5),
        .arst_n       (arst_n),
        .pix_strobe   (pix_strobe),
        .data         (blue),
        .c0           (hsync_p),
        .c1           (vsync_p),
        .de           (de_p),
        .symbol       (tmds_word_0)
    );

    tmds_encoder enc1
    (
        .clk_pixel_x5 (clk_pixel_x5),
        .arst_n       (arst_n),
        .pix_strobe   (pix_strobe),
        .data         (green),
        .c0           (1'b0),
        .c1           (1'b0),
        .de           (de_p),
        .symbol       (tmds_word_1)
    );

    tmds_encoder enc2
    (
        .clk_pixel_x5 (clk_pixel_x5),
        .arst_n       (arst_n),
        .pix_strobe   (pix_strobe),
        .data         (red),
        .c0           (1'b0),
        .c1           (1'b0),
        .de           (de_p),
        .symbol       (tmds_word_2)
    );

    serializer ser0
    (
        .clk_pixel_x5 (clk_pixel_x5),
        .arst_n       (arst_n),
        .pix_strobe   (pix_strobe),
        .tmds_word_0  (tmds_word_0),
        .tmds_word_1  (tmds_word_1),
        .tmds_word_2  (tmds_word_2),
        .tmds_0       (tmds_0),
        .tmds_1       (tmds_1),
        .tmds_2       (tmds_2),
        .tmds_clock   (tmds_clock)
    );

endmodule

`default_nettype wire

// ==== tb/tmds_model.svh ====
`ifndef TMDS_MODEL_SVH
`define TMDS_MODEL_SVH

// Numerical Recipes constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// Undo the DC balance inversion, then the XOR or XNOR chain
function automatic logic [7:0] tmds_decode(input logic [9:0] word);
    logic [7:0] d;
    logic [7:0] data;
    d       = word[9] ? ~word[7:0] : word[7:0];
    data[0] = d[0];
    for (int i = 1; i < 8; i++)
    begin
        data[i] = word[8] ? (d[i] ^ d[i-1]) : ~(d[i] ^ d[i-1]);
    end
    return data;
endfunction

function automatic logic is_ctrl(input logic [9:0] word);
    return (word == hdmi_pkg::tmds_ctrl0) || (word == hdmi_pkg::tmds_ctrl1) ||
           (word == hdmi_pkg::tmds_ctrl2) || (word == hdmi_pkg::tmds_ctrl3);
endfunction

// Sync pair {c1, c0} carried by a control word
function automatic logic [1:0] ctrl_pair(input logic [9:0] word);
    case (word)
        hdmi_pkg::tmds_ctrl1: return 2'b01;
        hdmi_pkg::tmds_ctrl2: return 2'b10;
        hdmi_pkg::tmds_ctrl3: return 2'b11;
        default:              return 2'b00;
    endcase
endfunction

function automatic logic hsync_at(input int h);
    return (h >= hdmi_pkg::h_active + hdmi_pkg::h_front) &&
           (h < hdmi_pkg::h_active + hdmi_pkg::h_front + hdmi_pkg::h_sync);
endfunction

// Expected {R, G, B} of active pixel idx
function automatic logic [23:0] pixel_model(input logic en, input hdmi_pkg::pattern_t pat,
                                            input logic [23:0] color, input int idx);
    logic [7:0] bar;
    logic [7:0] level;
    bar   = 8'(idx / 2);
    level = 8'(idx * 16);
    if (!en)
        return 24'h0;
    case (pat)
        hdmi_pkg::pat_solid: return color;
        hdmi_pkg::pat_bars:  return {{8{bar[2]}}, {8{bar[1]}}, {8{bar[0]}}};
        hdmi_pkg::pat_ramp:  return {level, level, level};
        default:             return 24'h0;
    endcase
endfunction

`endif

// ==== tb/hdmi_tx_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module hdmi_tx_tb;

    localparam int clk_period     = 8;
    localparam int frame_clocks   = hdmi_pkg::h_total * hdmi_pkg::v_total * hdmi_pkg::strobe_div;
    localparam int frame_checks   = 5;
    localparam int counted_frames = 2;
    // About one frame per check, plus start-up, sync search and margin
    localparam int watchdog_frames = frame_checks + counted_frames + 5;
    localparam int apb_xfers       = 64;
    localparam int watchdog_ns     = (watchdog_frames * frame_clocks + apb_xfers * 3) * clk_period;
    localparam int blank_len       = hdmi_pkg::h_total - hdmi_pkg::h_active;
    localparam int vsync_len       = hdmi_pkg::v_sync * hdmi_pkg::h_total;
    localparam int back_len        = hdmi_pkg::v_back * hdmi_pkg::h_total;

    logic        clk_pixel_x5;
    logic        arst_n;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [3:0]  paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
    logic [1:0]  tmds_0;
    logic [1:0]  tmds_1;
    logic [1:0]  tmds_2;
    logic [1:0]  tmds_clock;

    logic [31:0] rnd;
    // {lane 2, lane 1, lane 0} per pixel
    logic [29:0] sym_q [$];
    logic [29:0] cur;
    int          clock_words = 0;
    int          err_byte    = 0;
    int          err_ctrl    = 0;
    int          err_reg     = 0;
    int          err_pattern = 0;
    int          err_symbol  = 0;
    int          err_other   = 0;

    `include "tmds_model.svh"

    hdmi_tx dut0
    (
        .clk_pixel_x5 (clk_pixel_x5),
        .arst_n       (arst_n),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .tmds_0       (tmds_0),
        .tmds_1       (tmds_1),
        .tmds_2       (tmds_2),
        .tmds_clock   (tmds_clock)
    );

    initial
    begin
        clk_pixel_x5 = 1'b0;
        forever #(clk_period / 2) clk_pixel_x5 = ~clk_pixel_x5;
    end

    initial
    begin
        #(watchdog_ns);
        $display("Timeout: the video stream or an APB transfer stopped making progress");
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            err_byte++;
        end
    endtask

    task automatic check_ctrl(input string name, input logic [1:0] exp, input logic [1:0] act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            err_ctrl++;
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %h, actual %h", name, exp, act);
            err_reg++;
        end
    endtask

    task automatic check_pattern(input string name, input hdmi_pkg::pattern_t exp,
                                 input hdmi_pkg::pattern_t act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %0d, actual %0d", name, exp, act);
            err_pattern++;
        end
    endtask

    task automatic check_symbol(input string name, input logic [9:0] exp, input logic [9:0] act);
        if (act !== exp)
        begin
            $display("ERROR %s: expected %b, actual %b", name, exp, act);
            err_symbol++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("%s", msg);
        err_other++;
    endtask

    // Rebuild words from pairs, aligned where the clock lane goes from 0 to 1
    initial
    begin
        logic [9:0] win0;
        logic [9:0] win1;
        logic [9:0] win2;
        logic [9:0] winc;
        win0 = '0;
        win1 = '0;
        win2 = '0;
        winc = '0;
        forever
        begin
            @(negedge clk_pixel_x5);
            win0 = {tmds_0, win0[9:2]};
            win1 = {tmds_1, win1[9:2]};
            win2 = {tmds_2, win2[9:2]};
            winc = {tmds_clock, winc[9:2]};
            if (!winc[4] && winc[5])
            begin
                check_symbol("clock lane", hdmi_pkg::clock_lane_word, winc);
                clock_words++;
                sym_q.push_back({win2, win1, win0});
            end
        end
    end

    task automatic apb_xfer(input logic write, input logic [3:0] addr, input logic [31:0] wdata,
                            output logic [31:0] rdata, output logic err);
        @(posedge clk_pixel_x5);
        #1;
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(posedge clk_pixel_x5);
        #1;
        penable = 1'b1;
        // Response holds for the rest of the access cycle
        #2;
        rdata = prdata;
        err   = pslverr;
        check_reg("pready in access", 32'd1, {31'd0, pready});
        @(posedge clk_pixel_x5);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic configure_video(input logic en, input hdmi_pkg::pattern_t pat,
                                   input logic [23:0] color);
        logic [31:0] rdata;
        logic        err;
        apb_xfer(1'b1, hdmi_pkg::addr_color, {8'h00, color}, rdata, err);
        check_reg("color config error", 32'd0, {31'd0, err});
        apb_xfer(1'b1, hdmi_pkg::addr_ctrl, {29'd0, pat, en}, rdata, err);
        check_reg("ctrl config error", 32'd0, {31'd0, err});
    endtask

    task automatic fetch_word();
        while (sym_q.size() == 0)
            @(posedge clk_pixel_x5);
        cur = sym_q.pop_front();
    endtask

    function automatic logic in_vsync(input logic [29:0] w);
        logic [1:0] pair;
        pair = ctrl_pair(w[9:0]);
        return is_ctrl(w[9:0]) && pair[1];
    endfunction

    // Leaves cur on the first symbol of the next vsync pulse
    task automatic sync_to_vsync();
        fetch_word();
        while (in_vsync(cur))
            fetch_word();
        while (!in_vsync(cur))
            fetch_word();
    endtask

    task automatic verify_blank(input string name, input int h, input logic vs);
        logic [9:0] w;
        check_ctrl($sformatf("%s h %0d sync", name, h), {vs, hsync_at(h)}, ctrl_pair(cur[9:0]));
        for (int k = 1; k < 3; k++)
        begin
            w = cur[k*10 +: 10];
            if (!is_ctrl(w))
                report_failure($sformatf("%s: data symbol on lane %0d at blanking h %0d",
                                         name, k, h));
            else
                check_ctrl($sformatf("%s lane %0d h %0d", name, k, h), 2'b00, ctrl_pair(w));
        end
    endtask

    task automatic verify_frame(input string name, input logic en, input hdmi_pkg::pattern_t pat,
                                input logic [23:0] color);
        int          n;
        int          p;
        int          bal [3];
        logic [23:0] exp;
        sym_q.delete();
        sync_to_vsync();
        n = 0;
        while (in_vsync(cur))
        begin
            verify_blank(name, n % hdmi_pkg::h_total, 1'b1);
            n++;
            fetch_word();
        end
        check_reg({name, " vsync run"}, vsync_len, n);
        n = 0;
        while (is_ctrl(cur[9:0]))
        begin
            verify_blank(name, n % hdmi_pkg::h_total, 1'b0);
            n++;
            fetch_word();
        end
        check_reg({name, " back porch"}, back_len, n);
        for (int line = 0; line < hdmi_pkg::v_active; line++)
        begin
            p   = 0;
            bal = '{0, 0, 0};
            while (!is_ctrl(cur[9:0]))
            begin
                exp = pixel_model(en, pat, color, p);
                check_byte($sformatf("%s line %0d pixel %0d red", name, line, p),
                           exp[23:16], tmds_decode(cur[29:20]));
                check_byte($sformatf("%s line %0d pixel %0d green", name, line, p),
                           exp[15:8], tmds_decode(cur[19:10]));
                check_byte($sformatf("%s line %0d pixel %0d blue", name, line, p),
                           exp[7:0], tmds_decode(cur[9:0]));
                for (int k = 0; k < 3; k++)
                begin
                    bal[k] += 2 * $countones(cur[k*10 +: 10]) - 10;
                    if (bal[k] > 10 || bal[k] < -10)
                        report_failure($sformatf("%s line %0d: lane %0d DC balance reached %0d",
                                                 name, line, k, bal[k]));
                end
                p++;
                fetch_word();
            end
            check_reg($sformatf("%s line %0d active length", name, line), hdmi_pkg::h_active, p);
            n = 0;
            while (is_ctrl(cur[9:0]) && n < blank_len)
            begin
                verify_blank(name, hdmi_pkg::h_active + n, 1'b0);
                n++;
                fetch_word();
            end
            check_reg($sformatf("%s line %0d blanking length", name, line), blank_len, n);
        end
    endtask

    task automatic count_frames();
        logic [31:0] rdata;
        logic        err;
        logic [15:0] start;
        int          step;
        apb_xfer(1'b0, hdmi_pkg::addr_status, 32'd0, rdata, err);
        check_reg("status read error", 32'd0, {31'd0, err});
        start = rdata[15:0];
        sym_q.delete();
        repeat (counted_frames)
            sync_to_vsync();
        apb_xfer(1'b0, hdmi_pkg::addr_status, 32'd0, rdata, err);
        step = int'(rdata[15:0] - start);
        // The read may land on either side of a frame wrap
        if (step < counted_frames - 1 || step > counted_frames + 1)
            check_reg("frame counter step", counted_frames, step);
    endtask

    initial
    begin : main
        logic [31:0]        rdata;
        logic [31:0]        wdata;
        logic [31:0]        ctrl_exp;
        logic               err;
        logic               en;
        logic [3:0]         addr;
        logic [23:0]        color;
        hdmi_pkg::pattern_t pat;
        int                 total;
        arst_n  = 1'b0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = 4'h0;
        pwdata  = 32'd0;
        rnd     = 32'h647e_fc60;
        ctrl_exp = 32'd0;
        repeat (2) @(posedge clk_pixel_x5);
        #1;
        arst_n = 1'b1;

        for (int i = 0; i < 3; i++)
        begin
            rnd      = lcg_next(rnd);
            pat      = hdmi_pkg::pattern_t'(rnd[31:30] % 2'd3);
            en       = rnd[29];
            ctrl_exp = {29'd0, pat, en};
            apb_xfer(1'b1, hdmi_pkg::addr_ctrl, {rnd[28:0], pat, en}, rdata, err);
            check_reg("ctrl write error", 32'd0, {31'd0, err});
            apb_xfer(1'b0, hdmi_pkg::addr_ctrl, 32'd0, rdata, err);
            check_reg("ctrl readback", ctrl_exp, rdata);
            check_pattern("ctrl pattern field", pat, hdmi_pkg::pattern_t'(rdata[2:1]));
            rnd   = lcg_next(rnd);
            wdata = rnd;
            apb_xfer(1'b1, hdmi_pkg::addr_color, wdata, rdata, err);
            apb_xfer(1'b0, hdmi_pkg::addr_color, 32'd0, rdata, err);
            check_reg("color readback", {8'h00, wdata[23:0]}, rdata);
        end

        rnd = lcg_next(rnd);
        apb_xfer(1'b1, hdmi_pkg::addr_status, rnd, rdata, err);
        check_reg("status write error", 32'd1, {31'd0, err});
        check_reg("status write data", 32'd0, rdata);
        for (int i = 0; i < 3; i++)
        begin
            do
            begin
                rnd  = lcg_next(rnd);
                addr = rnd[27:24];
            end
            while (addr == hdmi_pkg::addr_ctrl || addr == hdmi_pkg::addr_color ||
                   addr == hdmi_pkg::addr_status);
            apb_xfer(1'b0, addr, 32'd0, rdata, err);
            check_reg($sformatf("unlisted read 0x%h error", addr), 32'd1, {31'd0, err});
            check_reg($sformatf("unlisted read 0x%h data", addr), 32'd0, rdata);
            apb_xfer(1'b1, addr, 32'hffff_ffff, rdata, err);
            check_reg($sformatf("unlisted write 0x%h error", addr), 32'd1, {31'd0, err});
        end
        apb_xfer(1'b0, hdmi_pkg::addr_ctrl, 32'd0, rdata, err);
        check_reg("ctrl after bad writes", ctrl_exp, rdata);

        for (int i = 0; i < 2; i++)
        begin
            rnd   = lcg_next(rnd);
            color = rnd[31:8];
            configure_video(1'b1, hdmi_pkg::pat_solid, color);
            verify_frame($sformatf("solid %h", color), 1'b1, hdmi_pkg::pat_solid, color);
        end
        rnd = lcg_next(rnd);
        configure_video(1'b1, hdmi_pkg::pat_bars, rnd[31:8]);
        verify_frame("bars", 1'b1, hdmi_pkg::pat_bars, rnd[31:8]);
        configure_video(1'b1, hdmi_pkg::pat_ramp, rnd[31:8]);
        verify_frame("ramp", 1'b1, hdmi_pkg::pat_ramp, rnd[31:8]);
        configure_video(1'b0, hdmi_pkg::pat_ramp, rnd[31:8]);
        verify_frame("disabled", 1'b0, hdmi_pkg::pat_ramp, rnd[31:8]);

        count_frames();

        if (clock_words == 0)
            report_failure("No clock lane words were captured");
        total = err_byte + err_ctrl + err_reg + err_pattern + err_symbol + err_other;
        $display("Errors: byte %0d, ctrl %0d, reg %0d, pattern %0d, symbol %0d, other %0d",
                 err_byte, err_ctrl, err_reg, err_pattern, err_symbol, err_other);
        if (total == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+tb
design/hdmi_pkg.sv
design/video_timing.sv
design/pattern_source.sv
design/tmds_encoder.sv
design/serializer.sv
design/apb_regs.sv
design/hdmi_tx.sv
tb/hdmi_tx_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator, then judge the run from its log
verilator --binary --timing --assert --top-module hdmi_tx_tb -f verilog.f \
    && ./obj_dir/Vhdmi_tx_tb > sim.log 2>&1 \
    ; cat sim.log \
    && ! grep -q -F '*** FAILED ***' sim.log \
    && grep -q -F '*** PASSED ***' sim.log \
    || { echo "Simulation did not pass"; exit 1; }
